// File: Bender.yml
package:
  name: dcache

sources:
  - src/dcache_geom_pkg.sv
  - src/dcache_port_pkg.sv
  - src/cleared_ram.sv
  - src/byte_bank_ram.sv
  - src/dcache_way.sv
  - src/dcache_ctrl.sv
  - src/dcache_top.sv
  - target: test
    files:
      - verification/clock_gen.sv
      - verification/dcache_tb.sv

// File: compile.f
src/dcache_geom_pkg.sv
src/dcache_port_pkg.sv
src/cleared_ram.sv
src/byte_bank_ram.sv
src/dcache_way.sv
src/dcache_ctrl.sv
src/dcache_top.sv
verification/clock_gen.sv
verification/dcache_tb.sv

// File: src/byte_bank_ram.sv
`timescale 1ns/1ps
`default_nettype none

module byte_bank_ram
    import dcache_geom_pkg::*;
(
    input  logic                      clk,
    input  logic                      en,
    input  logic [SET_W-1:0]          addr,
    input  logic [BYTES_PER_WORD-1:0] we,
    input  logic [WORD_W-1:0]         wdata,
    output logic [WORD_W-1:0]         rdata
);

    logic [WORD_W-1:0] mem [SETS];

    always_ff @(posedge clk) begin
        for (int b = 0; b < BYTES_PER_WORD; b++) begin
            if (we[b]) begin
                mem[addr][b*8 +: 8] <= wdata[b*8 +: 8];
            end
        end
        // Read only when no byte is being written.
        if (en && !(|we)) begin
            rdata <= mem[addr];
        end
    end

endmodule

`default_nettype wire

// File: src/cleared_ram.sv
`timescale 1ns/1ps
`default_nettype none

module cleared_ram #(
    parameter type entry_t = logic,
    parameter int  DEPTH   = 16
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     ren,
    input  logic [$clog2(DEPTH)-1:0] raddr,
    output entry_t                   rdata,
    input  logic                     we,
    input  logic [$clog2(DEPTH)-1:0] waddr,
    input  entry_t                   wdata
);

    entry_t mem [DEPTH];

    // Flop array, so the whole store can be wiped in one cycle.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= '0;
            end
            rdata <= '0;
        end else begin
            if (ren) begin
                rdata <= mem[raddr]; // Old data on a same-edge write.
            end
            if (we) begin
                mem[waddr] <= wdata;
            end
        end
    end

endmodule

`default_nettype wire

// File: src/dcache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_ctrl
    import dcache_geom_pkg::*;
    import dcache_port_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       core_req_valid,
    input  core_req_t  core_req,
    output logic       core_resp_valid,
    output core_resp_t core_resp,
    output way_ctrl_t  way_ctrl [WAYS],
    input  way_rd_t    way_rd [WAYS],
    output logic       mem_req_valid,
    output mem_req_t   mem_req,
    input  logic       mem_credit,
    input  logic       mem_resp_valid,
    input  mem_resp_t  mem_resp
);

    typedef enum logic [2:0] {
        S_IDLE, S_COMPARE, S_WB, S_REFILL_REQ, S_REFILL_WAIT, S_REPLAY
    } state_t;

    state_t                state;
    core_req_t             req;
    logic [SETS-1:0]       lru;          // Points at the next victim.
    logic [CREDIT_W-1:0]   credits;
    logic [WAY_W-1:0]      victim_way;
    logic [TAG_W-1:0]      victim_tag;
    logic [LINE_W-1:0]     victim_line;
    logic [SET_W-1:0]      lk_set;
    logic                  rd_en;
    logic [SET_W-1:0]      req_set;
    logic [TAG_W-1:0]      req_tag;
    logic [WORD_OFF_W-1:0] req_word;
    logic [WAYS-1:0]       hit_way;
    logic [WAY_W-1:0]      hit_idx;
    logic                  hit;
    logic                  store_hit;
    logic                  fill;
    logic [WAY_W-1:0]      lru_way;
    logic [WORD_W-1:0]     hit_word;

    assign req_set   = req.addr[SET_LSB +: SET_W];
    assign req_tag   = req.addr[TAG_LSB +: TAG_W];
    assign req_word  = req.addr[BYTE_OFF_W +: WORD_OFF_W];
    assign lru_way   = lru[req_set];
    assign rd_en     = (state == S_IDLE && core_req_valid) || state == S_REPLAY;
    assign lk_set    = (state == S_IDLE) ? core_req.addr[SET_LSB +: SET_W] : req_set;
    assign hit       = (state == S_COMPARE) && (|hit_way);
    assign store_hit = hit && req.write;
    assign fill      = (state == S_REFILL_WAIT) && mem_resp_valid;
    assign hit_word  = way_rd[hit_idx].data[req_word*WORD_W +: WORD_W];

    always_comb begin
        hit_idx = '0;
        for (int w = 0; w < WAYS; w++) begin
            hit_way[w] = way_rd[w].tagv.valid && (way_rd[w].tagv.tag == req_tag);
            if (hit_way[w]) begin
                hit_idx = WAY_W'(w);
            end
        end
    end

    // **********************************************************
    // Request sequencing.
    // **********************************************************
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state           <= S_IDLE;
            core_resp_valid <= 1'b0;
            lru             <= '0;
        end else begin
            core_resp_valid <= 1'b0;
            case (state)
                S_IDLE: if (core_req_valid) state <= S_COMPARE;
                S_COMPARE: begin
                    if (hit) begin
                        core_resp_valid <= 1'b1;
                        lru[req_set]    <= ~hit_idx;
                        state           <= S_IDLE;
                    end else if (way_rd[lru_way].tagv.valid && way_rd[lru_way].dirty) begin
                        state <= S_WB;
                    end else begin
                        state <= S_REFILL_REQ;
                    end
                end
                S_WB:          if (credits != '0) state <= S_REFILL_REQ;
                S_REFILL_REQ:  if (credits != '0) state <= S_REFILL_WAIT;
                S_REFILL_WAIT: if (mem_resp_valid) state <= S_REPLAY;
                S_REPLAY:      state <= S_COMPARE; // Reread the fresh line.
                default:       state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_IDLE && core_req_valid) begin
            req <= core_req;
        end
        if (hit) begin
            core_resp.rdata <= req.write ? '0 : hit_word;
        end
        if (state == S_COMPARE && !hit) begin
            victim_way  <= lru_way;
            victim_tag  <= way_rd[lru_way].tagv.tag;
            victim_line <= way_rd[lru_way].data;
        end
    end

    // **********************************************************
    // Memory side.
    // **********************************************************
    assign mem_req_valid = (state == S_WB || state == S_REFILL_REQ) && credits != '0;

    always_comb begin
        mem_req.write     = (state == S_WB);
        mem_req.line_addr = (state == S_WB) ? {victim_tag, req_set} : {req_tag, req_set};
        mem_req.data      = victim_line;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            credits <= CREDIT_W'(MEM_CREDITS);
        end else begin
            credits <= credits - CREDIT_W'(mem_req_valid) + CREDIT_W'(mem_credit);
        end
    end

    // Way commands. Reads share one index, writes use the held request.
    always_comb begin
        for (int w = 0; w < WAYS; w++) begin
            way_ctrl[w]                 = '0;
            way_ctrl[w].tagv_ren        = rd_en;
            way_ctrl[w].tagv_rindex     = lk_set;
            way_ctrl[w].tagv_windex     = req_set;
            way_ctrl[w].tagv_wdata.valid = 1'b1;
            way_ctrl[w].tagv_wdata.tag  = req_tag;
            way_ctrl[w].dirty_ren       = rd_en;
            way_ctrl[w].dirty_rindex    = lk_set;
            way_ctrl[w].dirty_windex    = req_set;
            for (int b = 0; b < LINE_WORDS; b++) begin
                way_ctrl[w].bank_en[b]     = rd_en;
                way_ctrl[w].bank_index[b]  = lk_set;
                way_ctrl[w].bank_windex[b] = req_set;
                way_ctrl[w].bank_wdata[b]  = fill ? mem_resp.data[b*WORD_W +: WORD_W]
                                                  : req.wdata;
            end
            if (fill && int'(victim_way) == w) begin
                way_ctrl[w].tagv_we     = 1'b1;
                way_ctrl[w].dirty_we    = 1'b1;
                way_ctrl[w].dirty_wdata = 1'b0;       // Refilled line is clean.
                way_ctrl[w].bank_we     = '1;
            end
            if (store_hit && hit_way[w]) begin
                way_ctrl[w].dirty_we          = 1'b1;
                way_ctrl[w].dirty_wdata       = 1'b1;
                way_ctrl[w].bank_we[req_word] = req.be;
            end
        end
    end

    // One refill per read request, and only while it is awaited.
    a_resp_expected: assert property (@(posedge clk) disable iff (!rst_n)
        mem_resp_valid |-> state == S_REFILL_WAIT);
    a_credit_max: assert property (@(posedge clk) disable iff (!rst_n)
        int'(credits) <= MEM_CREDITS);

endmodule

`default_nettype wire

// File: src/dcache_geom_pkg.sv
`default_nettype none

package dcache_geom_pkg;

    // **********************************************************
    // Address layout: tag | set | word | byte.
    // **********************************************************
    localparam int ADDR_W         = 16;
    localparam int WORD_W         = 32;
    localparam int BYTES_PER_WORD = 4;
    localparam int LINE_WORDS     = 4;
    localparam int SETS           = 16;
    localparam int SET_W          = 4;
    localparam int BYTE_OFF_W     = 2;
    localparam int WORD_OFF_W     = 2;
    localparam int SET_LSB        = BYTE_OFF_W + WORD_OFF_W;
    localparam int TAG_W          = ADDR_W - SET_W - SET_LSB; // Works out to 8.
    localparam int TAG_LSB        = SET_LSB + SET_W;
    localparam int LINE_W         = LINE_WORDS * WORD_W;

    // **********************************************************
    // Organisation and flow control.
    // **********************************************************
    localparam int WAYS           = 2;
    localparam int WAY_W          = 1;
    localparam int MEM_CREDITS    = 2;
    localparam int CREDIT_W       = $clog2(MEM_CREDITS + 1);

endpackage

`default_nettype wire

// File: src/dcache_port_pkg.sv
`default_nettype none

package dcache_port_pkg;
    import dcache_geom_pkg::*;

    typedef struct packed {
        logic                      write;
        logic [ADDR_W-1:0]         addr;
        logic [WORD_W-1:0]         wdata;
        logic [BYTES_PER_WORD-1:0] be;    // Stores only.
    } core_req_t;

    typedef struct packed {
        logic [WORD_W-1:0] rdata;
    } core_resp_t;

    typedef struct packed {
        logic                     write;     // Writeback when set.
        logic [TAG_W+SET_W-1:0]   line_addr;
        logic [LINE_W-1:0]        data;
    } mem_req_t;

    typedef struct packed {
        logic [LINE_W-1:0] data;
    } mem_resp_t;

    typedef struct packed {
        logic             valid;
        logic [TAG_W-1:0] tag;
    } tagv_t;

    typedef struct packed {
        logic                                     tagv_ren;
        logic [SET_W-1:0]                         tagv_rindex;
        logic                                     tagv_we;
        logic [SET_W-1:0]                         tagv_windex;
        tagv_t                                    tagv_wdata;
        logic                                     dirty_ren;
        logic [SET_W-1:0]                         dirty_rindex;
        logic                                     dirty_we;
        logic [SET_W-1:0]                         dirty_windex;
        logic                                     dirty_wdata;
        logic [LINE_WORDS-1:0]                    bank_en;
        logic [LINE_WORDS-1:0][SET_W-1:0]         bank_index;
        logic [LINE_WORDS-1:0][SET_W-1:0]         bank_windex;
        logic [LINE_WORDS-1:0][BYTES_PER_WORD-1:0] bank_we;
        logic [LINE_WORDS-1:0][WORD_W-1:0]        bank_wdata;
    } way_ctrl_t;

    typedef struct packed {
        tagv_t             tagv;
        logic              dirty;
        logic [LINE_W-1:0] data;
    } way_rd_t;

endpackage

`default_nettype wire

// File: src/dcache_top.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_top
    import dcache_geom_pkg::*;
    import dcache_port_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       core_req_valid,
    input  core_req_t  core_req,
    output logic       core_resp_valid,
    output core_resp_t core_resp,
    output logic       mem_req_valid,
    output mem_req_t   mem_req,
    input  logic       mem_credit,
    input  logic       mem_resp_valid,
    input  mem_resp_t  mem_resp
);

    way_ctrl_t way_ctrl [WAYS];
    way_rd_t   way_rd [WAYS];

    dcache_ctrl u_ctrl (
        .clk             (clk),
        .rst_n           (rst_n),
        .core_req_valid  (core_req_valid),
        .core_req        (core_req),
        .core_resp_valid (core_resp_valid),
        .core_resp       (core_resp),
        .way_ctrl        (way_ctrl),
        .way_rd          (way_rd),
        .mem_req_valid   (mem_req_valid),
        .mem_req         (mem_req),
        .mem_credit      (mem_credit),
        .mem_resp_valid  (mem_resp_valid),
        .mem_resp        (mem_resp)
    );

    for (genvar w = 0; w < WAYS; w++) begin : g_way
        dcache_way u_way (
            .clk   (clk),
            .rst_n (rst_n),
            .ctrl  (way_ctrl[w]),
            .rd    (way_rd[w])
        );
    end

endmodule

`default_nettype wire

// File: src/dcache_way.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_way
    import dcache_geom_pkg::*;
    import dcache_port_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  way_ctrl_t ctrl,
    output way_rd_t   rd
);

    tagv_t             tagv_q;
    logic              dirty_q;
    logic [WORD_W-1:0] bank_rdata [LINE_WORDS];

    cleared_ram #(
        .entry_t (tagv_t),
        .DEPTH   (SETS)
    ) u_tagv (
        .clk   (clk),
        .rst_n (rst_n),
        .ren   (ctrl.tagv_ren),
        .raddr (ctrl.tagv_rindex),
        .rdata (tagv_q),
        .we    (ctrl.tagv_we),
        .waddr (ctrl.tagv_windex),
        .wdata (ctrl.tagv_wdata)
    );

    cleared_ram #(
        .entry_t (logic),
        .DEPTH   (SETS)
    ) u_dirty (
        .clk   (clk),
        .rst_n (rst_n),
        .ren   (ctrl.dirty_ren),
        .raddr (ctrl.dirty_rindex),
        .rdata (dirty_q),
        .we    (ctrl.dirty_we),
        .waddr (ctrl.dirty_windex),
        .wdata (ctrl.dirty_wdata)
    );

    for (genvar i = 0; i < LINE_WORDS; i++) begin : g_bank
        byte_bank_ram u_bank (
            .clk   (clk),
            .en    (ctrl.bank_en[i]),
            .addr  ((|ctrl.bank_we[i]) ? ctrl.bank_windex[i] : ctrl.bank_index[i]),
            .we    (ctrl.bank_we[i]),
            .wdata (ctrl.bank_wdata[i]),
            .rdata (bank_rdata[i])
        );
    end

    always_comb begin
        rd.tagv  = tagv_q;
        rd.dirty = dirty_q;
        for (int i = 0; i < LINE_WORDS; i++) begin
            rd.data[i*WORD_W +: WORD_W] = bank_rdata[i]; // Word 0 in the low bits.
        end
    end

    // A new tag comes with its dirty bit, at the same set.
    a_tagv_dirty_pair: assert property (@(posedge clk) disable iff (!rst_n)
        ctrl.tagv_we |-> ctrl.dirty_we && ctrl.dirty_windex == ctrl.tagv_windex);
    a_dirty_on_valid: assert property (@(posedge clk) disable iff (!rst_n)
        ctrl.dirty_we && ctrl.dirty_wdata |-> tagv_q.valid); // Only a held line.

endmodule

`default_nettype wire

// File: verification/clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module clock_gen #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 3
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // Release just after an edge, like every other input.
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

// File: verification/dcache_stimulus.mem
// Columns: op addr wdata byte_enables expected. Op 0 load, 1 store, 2 load that must hit, f end.
// Stores expect zero response data.
0 1234 00000000 0 048dfb72
2 1234 00000000 0 048dfb72
2 1230 00000000 0 048cfb73
0 2238 00000000 0 088ef771
2 1234 00000000 0 048dfb72
1 4050 aabbccdd f 00000000
2 4050 00000000 0 aabbccdd
1 4054 11223344 5 00000000
2 4054 00000000 0 1022ef44
1 405c 12345678 3 00000000
2 405c 00000000 0 10175678
1 5050 cafef00d f 00000000
1 6050 0badc0de f 00000000
0 4054 00000000 0 1022ef44
2 4050 00000000 0 aabbccdd
2 4058 00000000 0 1016efe9
0 5050 00000000 0 cafef00d
0 6050 00000000 0 0badc0de
0 405c 00000000 0 10175678
0 0000 00000000 0 0000ffff
0 fffc 00000000 0 3fffc000
0 8a6c 00000000 0 229bdd64
1 8a6c 00000099 1 00000000
2 8a6c 00000000 0 229bdd99
0 9a60 00000000 0 2698d967
0 aa64 00000000 0 2a99d566
0 8a6c 00000000 0 229bdd99
f 0000 00000000 0 00000000

// File: verification/dcache_tb.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_tb
    import dcache_geom_pkg::*;
    import dcache_port_pkg::*;
();

    localparam int          MAX_OPS   = 28;
    localparam int          FIELDS    = 5;
    localparam int          MEM_WORDS = 1 << (ADDR_W - 2);
    localparam logic [31:0] OP_STORE  = 32'h1;
    localparam logic [31:0] OP_HIT    = 32'h2;
    localparam logic [31:0] OP_END    = 32'hf;

    logic       clk;
    logic       rst_n;
    logic       core_req_valid;
    core_req_t  core_req;
    logic       core_resp_valid;
    core_resp_t core_resp;
    logic       mem_req_valid;
    mem_req_t   mem_req;
    logic       mem_credit;
    logic       mem_resp_valid;
    mem_resp_t  mem_resp;

    logic [31:0]       stim [FIELDS*MAX_OPS];
    logic [WORD_W-1:0] mem_words [MEM_WORDS];
    logic [LINE_W-1:0] resp_line;
    logic [WORD_W-1:0] resp_data;
    int                credit_due [$];   // Cycle at which each credit goes back.
    int                seed;
    int                cycle;
    int                num_ops;
    int                core_credit;
    int                resp_count;
    int                resp_edge;
    int                outstanding;
    int                pending_credits;
    bit                read_pending;
    int                resp_due;
    int                reads_issued;
    int                reads_answered;

    clock_gen #(
        .PERIOD_NS    (100),
        .RESET_CYCLES (3)
    ) u_clock_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    dcache_top u_dcache_top (
        .clk             (clk),
        .rst_n           (rst_n),
        .core_req_valid  (core_req_valid),
        .core_req        (core_req),
        .core_resp_valid (core_resp_valid),
        .core_resp       (core_resp),
        .mem_req_valid   (mem_req_valid),
        .mem_req         (mem_req),
        .mem_credit      (mem_credit),
        .mem_resp_valid  (mem_resp_valid),
        .mem_resp        (mem_resp)
    );

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("RESULT: FAIL");
        $fatal(1, "Simulation stopped on error.");
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] expected);
        if (got !== expected) begin
            stop_with_failure($sformatf("ERROR: time %0t, %s: got %0h, expected %0h",
                                        $time, name, got, expected));
        end
    endtask

    task automatic check_idle_outputs();
        check_value("core_resp_valid", core_resp_valid, 1'b0);
        check_value("mem_req_valid", mem_req_valid, 1'b0);
    endtask

    // Upper half word address, lower half its inverse.
    task automatic init_memory();
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem_words[i] = {16'(i), ~16'(i)};
        end
    endtask

    task automatic load_stimulus();
        $readmemh("verification/dcache_stimulus.mem", stim);
        num_ops = 0;
        while (num_ops < MAX_OPS && stim[num_ops*FIELDS] !== OP_END) begin
            num_ops++;
        end
        if (num_ops == MAX_OPS) begin
            stop_with_failure("The stimulus file has no end marker.");
        end
    endtask

    // **********************************************************
    // Core side.
    // **********************************************************
    task automatic watch_core_response();
        if (core_resp_valid) begin
            if (core_credit != 0) begin
                stop_with_failure("A core response arrived with no request outstanding.");
            end
            core_credit = 1;
            resp_data   = core_resp.rdata;
            resp_edge   = cycle;
            resp_count++;
        end
    endtask

    task automatic run_op(input int idx);
        logic [31:0] op;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [31:0] be;
        logic [31:0] expected;
        int          req_edge;
        int          want;
        op       = stim[idx*FIELDS];
        addr     = stim[idx*FIELDS+1];
        wdata    = stim[idx*FIELDS+2];
        be       = stim[idx*FIELDS+3];
        expected = stim[idx*FIELDS+4];
        wait (core_credit == 1);
        @(posedge clk);
        #1;
        core_req_valid = 1'b1;
        core_req.write = (op == OP_STORE);
        core_req.addr  = addr[ADDR_W-1:0];
        core_req.wdata = wdata;
        core_req.be    = be[BYTES_PER_WORD-1:0];
        core_credit    = 0;
        req_edge       = cycle + 1; // Edge that samples the request.
        want           = resp_count + 1;
        @(posedge clk);
        #1;
        core_req_valid = 1'b0;
        wait (resp_count == want);
        check_value($sformatf("core_resp.rdata (op %0d)", idx), resp_data, expected);
        if (op == OP_HIT) begin
            check_value("hit response latency", resp_edge - req_edge, 2);
        end
    endtask

    // **********************************************************
    // Memory model.
    // **********************************************************
    task automatic sample_memory_port();
        int delay;
        if (mem_req_valid && outstanding >= MEM_CREDITS) begin
            stop_with_failure("A memory request was issued while the cache held no credit.");
        end
        outstanding = outstanding + int'(mem_req_valid) - int'(mem_credit);
        if (mem_req_valid) begin
            delay = 1 + int'($unsigned($random(seed)) % 4);
            credit_due.push_back(cycle + delay);
            if (mem_req.write) begin
                for (int i = 0; i < LINE_WORDS; i++) begin
                    mem_words[{mem_req.line_addr, WORD_OFF_W'(i)}] =
                        mem_req.data[i*WORD_W +: WORD_W];
                end
            end else begin
                if (read_pending) begin
                    stop_with_failure("A refill request came before the last one was answered.");
                end
                for (int i = 0; i < LINE_WORDS; i++) begin
                    resp_line[i*WORD_W +: WORD_W] =
                        mem_words[{mem_req.line_addr, WORD_OFF_W'(i)}];
                end
                read_pending = 1'b1;
                reads_issued++;
                resp_due = cycle + 1 + int'($unsigned($random(seed)) % 4);
            end
        end
    endtask

    task automatic drive_memory_port();
        int keep [$];
        foreach (credit_due[i]) begin
            if (credit_due[i] <= cycle) begin
                pending_credits++;
            end else begin
                keep.push_back(credit_due[i]);
            end
        end
        credit_due = keep;
        mem_credit = (pending_credits > 0); // One credit per pulse.
        if (mem_credit) begin
            pending_credits--;
        end
        mem_resp_valid = read_pending && resp_due <= cycle;
        if (mem_resp_valid) begin
            mem_resp.data = resp_line;
            read_pending  = 1'b0;
            reads_answered++;
        end
    endtask

    always @(posedge clk) begin
        cycle++;
        if (rst_n) begin
            watch_core_response();
            sample_memory_port();
            #1;
            drive_memory_port();
        end
    end

    initial begin
        wait (num_ops > 0);
        repeat (num_ops * 60 + 20) @(posedge clk);
        stop_with_failure("Watchdog expired before all operations completed.");
    end

    initial begin
        core_req_valid  = 1'b0;
        core_req        = '0;
        mem_credit      = 1'b0;
        mem_resp_valid  = 1'b0;
        mem_resp        = '0;
        seed            = 32'h0ec47dc3;
        cycle           = 0;
        core_credit     = 1;
        resp_count      = 0;
        outstanding     = 0;
        pending_credits = 0;
        read_pending    = 1'b0;
        reads_issued    = 0;
        reads_answered  = 0;
        init_memory();
        load_stimulus();
        @(posedge clk);
        while (!rst_n) begin
            @(posedge clk);
            check_idle_outputs();
        end
        repeat (2) begin
            @(posedge clk);
            check_idle_outputs();
        end
        for (int i = 0; i < num_ops; i++) begin
            run_op(i);
        end
        wait (outstanding == 0 && !read_pending);
        repeat (4) @(posedge clk);
        if (reads_issued == reads_answered) begin
            $display("RESULT: PASS");
            $finish;
        end else begin
            stop_with_failure("Refill requests and memory responses do not match.");
        end
    end

endmodule

`default_nettype wire
